// File: verilog/box_defines.svh
//******************************
// Widths, distance thresholds, servo limits,
// dodge time and debounce length
//******************************
`ifndef BOX_DEFINES_SVH
`define BOX_DEFINES_SVH

// Distance readings and servo amount
`define BOX_DIST_W      20
`define BOX_AMOUNT_W    5

// User counts as near below this distance
`define BOX_GOOD_DIS    20
// Sensor 1 sits closer to the switch than sensor 0
`define BOX_DELTA       4

`define BOX_SERVO_MAX   31
`define BOX_CLOSE_LIMIT 25
`define BOX_CLOSE_GAIN  3

`define BOX_DODGE_TIME  75
`define BOX_DEB_LEN     4

`endif

// File: verilog/box_mode_pkg.sv
//******************************
// Mode, behavior and engagement
// state encodings
//******************************
`default_nettype none

package box_mode_pkg;

    // Operating mode, normal switch or useless box
    typedef enum logic {
        MODE_NS,
        MODE_UB
    } box_mode_e;

    // Useless box behaviors, random means still choosing
    typedef enum logic [1:0] {
        BHV_RANDOM,
        BHV_CLASSIC,
        BHV_DODGE,
        BHV_ADVANCE
    } behavior_e;

    // Pending flip or running dodge
    typedef enum logic {
        ENG_IDLE,
        ENG_MOVE
    } engage_e;

endpackage

`default_nettype wire

// File: verilog/box_drive_pkg.sv
//******************************
// Distance, servo amount and
// motor pair types
//******************************
`default_nettype none
`include "box_defines.svh"

package box_drive_pkg;

    // Sonic distance reading
    typedef logic [`BOX_DIST_W-1:0] dist_t;

    // Servo lift amount
    typedef logic [`BOX_AMOUNT_W-1:0] servo_amount_t;

    // One bit per motor
    typedef logic [1:0] motor_pair_t;

endpackage

`default_nettype wire

// File: verilog/box_stage_if.sv
//******************************
// Stage interfaces sense_if
// and behave_if
//******************************
`default_nettype none

// Conditioned sensor view
interface sense_if ();
    // One cycle per debounced button press
    logic                 mode_pulse;
    // Min of sensor 0 and sensor 1 plus offset
    box_drive_pkg::dist_t near_dist;
    // User is closer to the right side
    logic                 side_right;
    // Any IR sensor sees an object
    logic                 ir_hit;

    modport source (output mode_pulse, near_dist, side_right, ir_hit);
    modport sink   (input  mode_pulse, near_dist, side_right, ir_hit);
endinterface

// Behavior decisions toward actuation
interface behave_if ();
    box_mode_pkg::box_mode_e mode;
    box_mode_pkg::behavior_e behavior;
    logic                    engaged;
    // Switch is off its target position
    logic                    mismatch;
    // Invalid behavior request in UB
    logic                    err;

    modport source (output mode, behavior, engaged, mismatch, err);
    modport sink   (input  mode, behavior, engaged, mismatch, err);
endinterface

`default_nettype wire

// File: verilog/sense_stage.sv
//******************************
// Sensor conditioning stage
// Debouncers, mode press pulse,
// nearest distance and side flag
//******************************
`default_nettype none
`include "box_defines.svh"

module sense_stage (
    input  wire                       clk,
    input  wire                       rst,
    input  wire                       mode_btn,
    input  wire [3:0]                 ir_sensor,
    input  wire box_drive_pkg::dist_t distance_0,
    input  wire box_drive_pkg::dist_t distance_1,
    sense_if.source                   sense
);
    // Line 0 is the button, lines 1 to 4 are the IR sensors
    localparam int LINES = 5;

    logic [LINES-1:0]        raw;
    logic [`BOX_DEB_LEN-1:0] deb_sr [LINES];
    logic [LINES-1:0]        deb;
    logic                    btn_q;
    logic [`BOX_DIST_W:0]    dist_1_adj;

    // IR is active low, flip so 1 means object present
    assign raw = {~ir_sensor, mode_btn};

    // Extra bit keeps the offset sum from wrapping
    assign dist_1_adj = {1'b0, distance_1} + (`BOX_DIST_W + 1)'(`BOX_DELTA);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < LINES; i++) begin
                deb_sr[i] <= '0;
            end
            deb   <= '0;
            btn_q <= 1'b0;
        end else begin
            for (int i = 0; i < LINES; i++) begin
                deb_sr[i] <= {deb_sr[i][`BOX_DEB_LEN-2:0], raw[i]};
                // Level accepted only after a full run of equal samples
                if (&deb_sr[i]) begin
                    deb[i] <= 1'b1;
                end else if (~|deb_sr[i]) begin
                    deb[i] <= 1'b0;
                end
            end
            btn_q <= deb[0];
        end
    end

    // Rising edge of the clean button
    assign sense.mode_pulse = deb[0] & ~btn_q;
    assign sense.ir_hit     = |deb[LINES-1:1];

    // Nearest distance and side, so later stages never see raw sensors
    always_ff @(posedge clk) begin
        if ({1'b0, distance_0} > dist_1_adj) begin
            // Fits in dist_t since it is below distance_0
            sense.near_dist  <= dist_1_adj[`BOX_DIST_W-1:0];
            sense.side_right <= 1'b1;
        end else begin
            sense.near_dist  <= distance_0;
            sense.side_right <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: verilog/behavior_stage.sv
//******************************
// Behavior stage
// Mode, behavior and engagement FSMs,
// dodge timer, LFSR, toggle handshake
//******************************
`default_nettype none
`include "box_defines.svh"

module behavior_stage (
    input  wire       clk,
    input  wire       rst,
    input  wire [2:0] wanted_ub,
    input  wire       sw0,
    input  wire       toggle_req,
    output logic      toggle_ack,
    sense_if.sink     sense,
    behave_if.source  behave
);
    localparam int CNT_W = $clog2(`BOX_DODGE_TIME + 1);

    box_mode_pkg::box_mode_e mode, mode_next;
    box_mode_pkg::behavior_e bhv, bhv_next, wanted_bhv;
    box_mode_pkg::engage_e   eng, eng_next;
    logic                    wanted_ok, err, ub_active;
    logic [CNT_W-1:0]        dodge_cnt;
    logic [7:0]              lfsr;
    logic [1:0]              sw0_sync;
    logic                    target, near_user, dodge_done;

    // Each press toggles between NS and UB
    always_comb begin
        mode_next = mode;
        if (sense.mode_pulse) begin
            mode_next = (mode == box_mode_pkg::MODE_NS) ? box_mode_pkg::MODE_UB
                                                        : box_mode_pkg::MODE_NS;
        end
    end

    // One-hot request, anything else is an error
    always_comb begin
        wanted_ok = 1'b1;
        case (wanted_ub)
            3'b000:  wanted_bhv = box_mode_pkg::BHV_RANDOM;
            3'b001:  wanted_bhv = box_mode_pkg::BHV_CLASSIC;
            3'b010:  wanted_bhv = box_mode_pkg::BHV_DODGE;
            3'b100:  wanted_bhv = box_mode_pkg::BHV_ADVANCE;
            default: begin
                wanted_bhv = box_mode_pkg::BHV_RANDOM;
                wanted_ok  = 1'b0;
            end
        endcase
    end

    // Gated on the next mode so nothing stays engaged across a mode change
    assign ub_active  = (mode_next == box_mode_pkg::MODE_UB) && wanted_ok;
    assign near_user  = sense.near_dist < box_drive_pkg::dist_t'(`BOX_GOOD_DIS);
    assign dodge_done = (dodge_cnt == CNT_W'(`BOX_DODGE_TIME - 1));

    // Engagement
    always_comb begin
        eng_next = box_mode_pkg::ENG_IDLE;
        if (ub_active) begin
            case (bhv)
                box_mode_pkg::BHV_CLASSIC, box_mode_pkg::BHV_ADVANCE: begin
                    if (behave.mismatch) begin
                        eng_next = box_mode_pkg::ENG_MOVE;
                    end
                end
                box_mode_pkg::BHV_DODGE: begin
                    if (eng == box_mode_pkg::ENG_IDLE) begin
                        eng_next = near_user ? box_mode_pkg::ENG_MOVE : box_mode_pkg::ENG_IDLE;
                    end else begin
                        eng_next = dodge_done ? box_mode_pkg::ENG_IDLE : box_mode_pkg::ENG_MOVE;
                    end
                end
                default: eng_next = box_mode_pkg::ENG_IDLE;
            endcase
        end
    end

    // Behavior, random choice from LFSR low bits
    always_comb begin
        bhv_next = box_mode_pkg::BHV_RANDOM;
        if (ub_active) begin
            if (wanted_bhv != box_mode_pkg::BHV_RANDOM) begin
                bhv_next = wanted_bhv;
            end else if (bhv == box_mode_pkg::BHV_RANDOM) begin
                case (lfsr[1:0])
                    2'd0:    bhv_next = box_mode_pkg::BHV_ADVANCE;
                    2'd1:    bhv_next = box_mode_pkg::BHV_CLASSIC;
                    2'd2:    bhv_next = box_mode_pkg::BHV_DODGE;
                    default: bhv_next = box_mode_pkg::BHV_RANDOM;
                endcase
            end else if (eng == box_mode_pkg::ENG_MOVE && eng_next == box_mode_pkg::ENG_IDLE) begin
                // Engagement over, choose again
                bhv_next = box_mode_pkg::BHV_RANDOM;
            end else begin
                bhv_next = bhv;
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            mode       <= box_mode_pkg::MODE_NS;
            bhv        <= box_mode_pkg::BHV_RANDOM;
            eng        <= box_mode_pkg::ENG_IDLE;
            err        <= 1'b0;
            dodge_cnt  <= '0;
            lfsr       <= 8'h01;
            sw0_sync   <= 2'b00;
            target     <= 1'b0;
            toggle_ack <= 1'b0;
        end else begin
            mode     <= mode_next;
            bhv      <= bhv_next;
            eng      <= eng_next;
            err      <= (mode_next == box_mode_pkg::MODE_UB) && !wanted_ok;
            // x^8 + x^6 + x^5 + x^4 + 1
            lfsr     <= {lfsr[6:0], lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3]};
            sw0_sync <= {sw0_sync[0], sw0};
            // Dodge timer runs only while a dodge stays engaged
            if (bhv == box_mode_pkg::BHV_DODGE && eng == box_mode_pkg::ENG_MOVE
                    && eng_next == box_mode_pkg::ENG_MOVE) begin
                dodge_cnt <= dodge_cnt + 1'b1;
            end else begin
                dodge_cnt <= '0;
            end
            // Four-phase toggle, no ack in UB
            if (toggle_ack) begin
                if (!toggle_req) begin
                    toggle_ack <= 1'b0;
                end
            end else if (toggle_req && mode == box_mode_pkg::MODE_NS) begin
                toggle_ack <= 1'b1;
                target     <= ~target;
            end
        end
    end

    assign behave.mode     = mode;
    assign behave.behavior = bhv;
    assign behave.engaged  = (eng == box_mode_pkg::ENG_MOVE);
    assign behave.mismatch = sw0_sync[1] ^ target;
    assign behave.err      = err;

    ack_after_req: assert property (@(posedge clk) disable iff (rst)
        $rose(toggle_ack) |-> $past(toggle_req) && $past(mode) == box_mode_pkg::MODE_NS);

    engaged_in_ub: assert property (@(posedge clk) disable iff (rst)
        behave.engaged |-> behave.mode == box_mode_pkg::MODE_UB);

endmodule

`default_nettype wire

// File: verilog/actuate_stage.sv
//******************************
// Actuation stage
// Registered servo, motor and relay commands
//******************************
`default_nettype none
`include "box_defines.svh"

module actuate_stage (
    input  wire                          clk,
    input  wire                          rst,
    input  wire                          sw0,
    sense_if.sink                        sense,
    behave_if.sink                       behave,
    output logic                         servo_enable,
    output logic                         servo_sel,
    output box_drive_pkg::servo_amount_t servo_amount,
    output box_drive_pkg::motor_pair_t   motor_cw,
    output box_drive_pkg::motor_pair_t   motor_ccw,
    output logic                         relay
);
    localparam int PROD_W = `BOX_DIST_W + 2;
    localparam box_drive_pkg::servo_amount_t AMT_MAX =
        box_drive_pkg::servo_amount_t'(`BOX_SERVO_MAX);

    logic                         ns_mode, push, advance, dodge_run, stop_zone;
    logic [PROD_W-1:0]            close_prod;
    box_drive_pkg::servo_amount_t close_amt, amount_next;
    logic                         enable_next, sel_next;

    assign ns_mode = (behave.mode == box_mode_pkg::MODE_NS);
    assign advance = !behave.err && behave.behavior == box_mode_pkg::BHV_ADVANCE;
    // Push the switch back toward its target
    assign push    = ns_mode || advance
                  || (!behave.err && behave.behavior == box_mode_pkg::BHV_CLASSIC);

    // Closer effect, lift rises as the user approaches
    assign close_prod = {2'b00, sense.near_dist} * PROD_W'(`BOX_CLOSE_GAIN);
    always_comb begin
        if (sense.ir_hit) begin
            close_amt = AMT_MAX;
        end else if (sense.near_dist > box_drive_pkg::dist_t'(`BOX_GOOD_DIS)) begin
            close_amt = '0;
        end else if (close_prod < PROD_W'(`BOX_CLOSE_LIMIT)) begin
            close_amt = close_prod[`BOX_AMOUNT_W-1:0];
        end else begin
            close_amt = AMT_MAX;
        end
    end

    always_comb begin
        enable_next = 1'b1;
        sel_next    = sw0;
        amount_next = '0;
        if (behave.mismatch) begin
            if (push) begin
                sel_next    = ~sw0;
                // Back off while a hand is at the switch
                amount_next = sense.ir_hit ? '0 : AMT_MAX;
            end
        end else if (ns_mode) begin
            enable_next = 1'b0;
            sel_next    = 1'b0;
        end else if (advance) begin
            sel_next    = ~sw0;
            amount_next = close_amt;
        end
    end

    // Motors stop when very close or when the user is far away
    assign dodge_run = !ns_mode && !behave.err && behave.behavior == box_mode_pkg::BHV_DODGE;
    assign stop_zone = (sense.near_dist < box_drive_pkg::dist_t'(`BOX_GOOD_DIS / 3 + 1))
                    || (sense.near_dist > box_drive_pkg::dist_t'(`BOX_GOOD_DIS / 2));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            servo_enable <= 1'b0;
            motor_cw     <= 2'b00;
            motor_ccw    <= 2'b00;
            relay        <= 1'b0;
        end else begin
            servo_enable <= enable_next;
            motor_cw     <= (dodge_run && !stop_zone && sense.side_right) ? 2'b11 : 2'b00;
            motor_ccw    <= (dodge_run && !stop_zone && !sense.side_right) ? 2'b11 : 2'b00;
            relay        <= ns_mode & sw0;
        end
    end

    always_ff @(posedge clk) begin
        servo_sel    <= sel_next;
        servo_amount <= amount_next;
    end

    motor_exclusive: assert property (@(posedge clk) disable iff (rst)
        (motor_cw | motor_ccw) != 2'b00 |-> (motor_cw & motor_ccw) == 2'b00
            && $past(behave.behavior) == box_mode_pkg::BHV_DODGE);

endmodule

`default_nettype wire

// File: verilog/useless_box_top.sv
//******************************
// Switch box controller top
// Sense, behavior and actuation stages
//******************************
`default_nettype none

module useless_box_top (
    input  wire                          clk,
    input  wire                          rst,
    input  wire                          mode_btn,
    input  wire [2:0]                    wanted_ub,
    input  wire                          sw0,
    input  wire [3:0]                    ir_sensor,
    input  wire box_drive_pkg::dist_t    distance_0,
    input  wire box_drive_pkg::dist_t    distance_1,
    input  wire                          toggle_req,
    output logic                         toggle_ack,
    output logic                         mode_ub,
    output logic                         ub_err,
    output logic                         servo_enable,
    output logic                         servo_sel,
    output box_drive_pkg::servo_amount_t servo_amount,
    output box_drive_pkg::motor_pair_t   motor_cw,
    output box_drive_pkg::motor_pair_t   motor_ccw,
    output logic                         relay
);
    sense_if  sense_bus ();
    behave_if behave_bus ();

    // Conditioning, then decisions, then drive
    sense_stage u_sense (
        .clk        (clk),
        .rst        (rst),
        .mode_btn   (mode_btn),
        .ir_sensor  (ir_sensor),
        .distance_0 (distance_0),
        .distance_1 (distance_1),
        .sense      (sense_bus.source)
    );

    behavior_stage u_behavior (
        .clk        (clk),
        .rst        (rst),
        .wanted_ub  (wanted_ub),
        .sw0        (sw0),
        .toggle_req (toggle_req),
        .toggle_ack (toggle_ack),
        .sense      (sense_bus.sink),
        .behave     (behave_bus.source)
    );

    actuate_stage u_actuate (
        .clk          (clk),
        .rst          (rst),
        .sw0          (sw0),
        .sense        (sense_bus.sink),
        .behave       (behave_bus.sink),
        .servo_enable (servo_enable),
        .servo_sel    (servo_sel),
        .servo_amount (servo_amount),
        .motor_cw     (motor_cw),
        .motor_ccw    (motor_ccw),
        .relay        (relay)
    );

    assign mode_ub = (behave_bus.mode == box_mode_pkg::MODE_UB);
    assign ub_err  = behave_bus.err;

endmodule

`default_nettype wire

// File: bench/tb_clock.sv
//******************************
// Testbench clock, 8 ns period
//******************************
`default_nettype none

module tb_clock (
    output logic clk
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
    end

    // Half period
    always #4 clk = ~clk;

endmodule

`default_nettype wire

// File: bench/tb_useless_box.sv
//******************************
// Switch box controller testbench
// Stimulus, assertion checks, timeout
//******************************
`default_nettype none
`include "box_defines.svh"

module tb_useless_box;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int MAX_CYCLES = 3000;
    // Longest input path is the IR debounce plus two registers
    localparam int SETTLE = 6;

    logic                         clk;
    logic                         rst;
    logic                         mode_btn;
    logic [2:0]                   wanted_ub;
    logic                         sw0;
    logic [3:0]                   ir_sensor;
    box_drive_pkg::dist_t         distance_0;
    box_drive_pkg::dist_t         distance_1;
    logic                         toggle_req;
    logic                         toggle_ack;
    logic                         mode_ub;
    logic                         ub_err;
    logic                         servo_enable;
    logic                         servo_sel;
    box_drive_pkg::servo_amount_t servo_amount;
    box_drive_pkg::motor_pair_t   motor_cw;
    box_drive_pkg::motor_pair_t   motor_ccw;
    logic                         relay;

    int   seed = 2;
    int   cycles = 0;
    int   last_change = 0;
    // Number of the running test
    // Zero turns the test specific checks off
    int   phase = 0;
    // Switch position the box should hold
    logic target = 1'b0;
    logic settled;
    logic ir_on;

    tb_clock clock_gen (.clk(clk));

    useless_box_top dut (.*);

    assign settled = (cycles - last_change) >= SETTLE;
    // Active low sensors
    assign ir_on   = ~&ir_sensor;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Regression failed");
        $fatal(1, "run stopped");
    endtask

    task automatic report_error(input string msg);
        abort_run($sformatf("error at %0t ns: %s", $time, msg));
    endtask

    // Nearest reading with the box offset on sensor 1
    function automatic int nearest(input int d0, input int d1);
        if (d0 > d1 + `BOX_DELTA) begin
            return d1 + `BOX_DELTA;
        end
        return d0;
    endfunction

    function automatic int closer_amount(input int near, input logic ir);
        if (ir) begin
            return `BOX_SERVO_MAX;
        end else if (near > `BOX_GOOD_DIS) begin
            return 0;
        end else if (near * `BOX_CLOSE_GAIN < `BOX_CLOSE_LIMIT) begin
            return near * `BOX_CLOSE_GAIN;
        end
        return `BOX_SERVO_MAX;
    endfunction

    // Motor result is 0 for stop, 1 for cw and 2 for ccw
    function automatic int motor_state(input int d0, input int d1);
        int near;
        near = nearest(d0, d1);
        if (near < `BOX_GOOD_DIS / 3 + 1 || near > `BOX_GOOD_DIS / 2) begin
            return 0;
        end
        return (d0 > d1 + `BOX_DELTA) ? 1 : 2;
    endfunction

    reset_idle: assert property (@(posedge clk) disable iff (rst)
        phase == 1 |-> !toggle_ack && motor_cw == 2'b00 && motor_ccw == 2'b00 && !ub_err)
        else report_error("outputs not idle after reset");

    // Tests 1 and 2 run in normal mode, all later ones after the single press
    mode_check: assert property (@(posedge clk) disable iff (rst)
        phase != 0 && settled |-> mode_ub == (phase >= 3))
        else report_error("wrong mode_ub");

    relay_follows: assert property (@(posedge clk) disable iff (rst)
        settled && !mode_ub |-> relay == sw0)
        else report_error("relay does not follow sw0 in normal mode");

    relay_off_ub: assert property (@(posedge clk) disable iff (rst)
        settled && mode_ub |-> !relay)
        else report_error("relay on in useless box mode");

    // Four phase toggle handshake
    ack_rises: assert property (@(posedge clk) disable iff (rst)
        !mode_ub && toggle_req && !toggle_ack |=> toggle_ack)
        else report_error("toggle request not acknowledged in normal mode");

    ack_falls: assert property (@(posedge clk) disable iff (rst)
        toggle_ack && !toggle_req |=> !toggle_ack)
        else report_error("toggle_ack did not fall after toggle_req");

    no_ack_ub: assert property (@(posedge clk) disable iff (rst)
        mode_ub && toggle_req |-> !toggle_ack)
        else report_error("toggle request acknowledged in useless box mode");

    ns_servo: assert property (@(posedge clk) disable iff (rst)
        phase == 2 && settled |-> (sw0 != target)
            ? (servo_enable && servo_sel == !sw0
                && int'(servo_amount) == (ir_on ? 0 : `BOX_SERVO_MAX))
            : !servo_enable)
        else report_error("wrong servo command in normal mode");

    classic_push: assert property (@(posedge clk) disable iff (rst)
        phase == 3 && settled |-> servo_enable && servo_sel == !sw0
            && int'(servo_amount) == (ir_on ? 0 : `BOX_SERVO_MAX))
        else report_error("wrong classic push");

    advance_closer: assert property (@(posedge clk) disable iff (rst)
        phase == 4 && settled |-> servo_sel == !sw0 && int'(servo_amount)
            == closer_amount(nearest(int'(distance_0), int'(distance_1)), ir_on))
        else report_error("wrong closer effect amount");

    dodge_motors: assert property (@(posedge clk) disable iff (rst)
        phase == 5 && settled |-> int'(servo_amount) == 0
            && motor_cw == ((motor_state(int'(distance_0), int'(distance_1)) == 1)
                ? 2'b11 : 2'b00)
            && motor_ccw == ((motor_state(int'(distance_0), int'(distance_1)) == 2)
                ? 2'b11 : 2'b00))
        else report_error("wrong dodge motor drive");

    random_pick: assert property (@(posedge clk) disable iff (rst)
        phase == 6 && settled |-> !ub_err
            && (int'(servo_amount) == 0 || int'(servo_amount) == `BOX_SERVO_MAX))
        else report_error("wrong servo amount for a random behavior");

    invalid_pick: assert property (@(posedge clk) disable iff (rst)
        phase == 7 && settled |-> ub_err && int'(servo_amount) == 0
            && motor_cw == 2'b00 && motor_ccw == 2'b00)
        else report_error("invalid behavior request not flagged");

    // Cycle count and run limit
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            abort_run($sformatf("timeout, run still going after %0d cycles", MAX_CYCLES));
        end
    end

    task automatic mark_change();
        last_change = cycles;
    endtask

    task automatic hold(input int n);
        repeat (n) @(negedge clk);
    endtask

    // Small readings so every threshold gets crossed
    task automatic new_distances();
        distance_0 = box_drive_pkg::dist_t'($random(seed) & 31);
        distance_1 = box_drive_pkg::dist_t'($random(seed) & 31);
        mark_change();
    endtask

    task automatic toggle_target();
        toggle_req = 1'b1;
        mark_change();
        while (!toggle_ack) begin
            @(negedge clk);
        end
        target     = ~target;
        toggle_req = 1'b0;
        mark_change();
        while (toggle_ack) begin
            @(negedge clk);
        end
    endtask

    // Press until the mode flips and release
    task automatic press_mode();
        phase    = 0;
        mode_btn = 1'b1;
        mark_change();
        while (!mode_ub) begin
            @(negedge clk);
        end
        mode_btn = 1'b0;
        mark_change();
    endtask

    initial begin
        rst        = 1'b1;
        mode_btn   = 1'b0;
        wanted_ub  = 3'b000;
        sw0        = 1'b0;
        ir_sensor  = 4'hF;
        distance_0 = 20'd50;
        distance_1 = 20'd50;
        toggle_req = 1'b0;
        hold(10);
        rst = 1'b0;
        mark_change();
        phase = 1;
        hold(10);

        // Normal mode push and handshake
        phase = 2;
        sw0   = 1'b1;
        mark_change();
        hold(9);
        ir_sensor = 4'b1110;
        mark_change();
        hold(9);
        ir_sensor = 4'hF;
        mark_change();
        hold(9);
        toggle_target();
        hold(9);
        toggle_target();
        hold(9);
        sw0 = 1'b0;
        mark_change();
        hold(9);

        // Classic push with a request ignored in UB
        wanted_ub = 3'b001;
        press_mode();
        phase = 3;
        sw0   = ~target;
        mark_change();
        hold(9);
        ir_sensor = 4'b0111;
        mark_change();
        hold(9);
        ir_sensor = 4'hF;
        mark_change();
        hold(9);
        toggle_req = 1'b1;
        hold(12);
        toggle_req = 1'b0;
        hold(4);

        // Advance closer effect with IR on for the last readings
        phase     = 4;
        wanted_ub = 3'b100;
        sw0       = target;
        for (int i = 0; i < 16; i++) begin
            if (i == 12) begin
                ir_sensor = 4'b1011;
            end
            new_distances();
            hold(9);
        end

        // Dodge motors
        phase     = 5;
        wanted_ub = 3'b010;
        ir_sensor = 4'hF;
        for (int i = 0; i < 14; i++) begin
            new_distances();
            hold(9);
        end

        // Random choice followed by an invalid request
        phase     = 6;
        wanted_ub = 3'b000;
        sw0       = ~target;
        mark_change();
        hold(40);
        phase     = 7;
        wanted_ub = 3'b011;
        mark_change();
        hold(20);

        phase = 0;
        $display("Regression passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: sim.f
+incdir+verilog
verilog/box_mode_pkg.sv
verilog/box_drive_pkg.sv
verilog/box_stage_if.sv
verilog/sense_stage.sv
verilog/behavior_stage.sv
verilog/actuate_stage.sv
verilog/useless_box_top.sv
bench/tb_clock.sv
bench/tb_useless_box.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the switch box testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
    -f sim.f --top-module tb_useless_box
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/Vtb_useless_box 2>&1)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "Simulation returned status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -q "^Regression passed$"; then
    exit 0
fi
exit 1
